/* Makefile */
# Verilator build and run for the UART testbench

TOP := tb_uart

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f filelist.f --top-module $(TOP) -Mdir obj_dir

# Pass only if the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

/* filelist.f */
hdl/uart_timing_pkg.sv
hdl/uart_csr_pkg.sv
hdl/uart_tick_gen.sv
hdl/uart_fifo.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_csr.sv
hdl/uart_top.sv
tb/tb_uart.sv

/* hdl/uart_csr.sv */
// UART register block

`timescale 1ns/1ps

module uart_csr (
   input  logic                               clk,
   input  logic                               arst_n,
   input  uart_csr_pkg::csr_addr_t            csr_addr,
   input  logic                               csr_wr,
   input  logic                               csr_rd,
   input  logic [uart_timing_pkg::data_w-1:0] csr_wdata,
   output logic [uart_timing_pkg::data_w-1:0] csr_rdata,
   input  logic [uart_timing_pkg::data_w-1:0] rx_head,
   input  logic                               rx_empty,
   input  logic                               rx_full,
   input  logic                               rx_push,
   input  logic                               tx_full,
   output logic                               rx_pop,
   output logic                               tx_push,
   output logic [uart_timing_pkg::data_w-1:0] tx_wdata
);

   uart_csr_pkg::csr_word_u rd_word;
   logic                    rx_oflow;
   logic                    sel_data;

   // ------------------------------
   // Address decode
   // ------------------------------
   assign sel_data = (csr_addr == uart_csr_pkg::csr_addr_data);
   // FIFOs drop the strobe when full or empty
   assign tx_push  = csr_wr && sel_data;
   assign rx_pop   = csr_rd && sel_data;
   assign tx_wdata = csr_wdata;

   // Read word per address
   always_comb begin
      rd_word = '0;
      case (csr_addr)
         uart_csr_pkg::csr_addr_data: begin
            rd_word.data = rx_head;
         end
         uart_csr_pkg::csr_addr_status: begin
            rd_word.status.tx_busy  = tx_full;
            rd_word.status.rx_oflow = rx_oflow;
            rd_word.status.rx_valid = !rx_empty;
         end
         default: rd_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!arst_n) begin
         rx_oflow  <= 1'b0;
         csr_rdata <= '0;
      end else begin
         // Lost byte, set beats clear-on-read
         if (rx_push && rx_full) begin
            rx_oflow <= 1'b1;
         end else if (rx_pop) begin
            rx_oflow <= 1'b0;
         end
         // Held until the next read
         if (csr_rd) begin
            csr_rdata <= rd_word.data;
         end
      end
   end

   // FIFO strobes only come from the DATA register
   a_data_only: assert property (@(posedge clk) disable iff (!arst_n)
      (rx_pop || tx_push) |-> (csr_addr == uart_csr_pkg::csr_addr_data));

endmodule

/* hdl/uart_csr_pkg.sv */
// UART register map

package uart_csr_pkg;

   // Register address
   typedef logic [1:0] csr_addr_t;

   localparam csr_addr_t csr_addr_data   = 2'd0;
   localparam csr_addr_t csr_addr_status = 2'd1;
   // Addresses 2 and 3 read as zero

   // STATUS layout, rx_valid in bit 0
   typedef struct packed {
      logic [4:0] rsvd;
      logic       tx_busy;
      logic       rx_oflow;
      logic       rx_valid;
   } csr_status_t;

   // Read word, seen as a data byte or as status flags by address
   typedef union packed {
      logic [uart_timing_pkg::data_w-1:0] data;
      csr_status_t                        status;
   } csr_word_u;

endpackage

/* hdl/uart_fifo.sv */
// Fall-through byte FIFO

`timescale 1ns/1ps

module uart_fifo #(
   parameter int fifo_aw = 4
) (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic [uart_timing_pkg::data_w-1:0] din,
   input  logic                               push,
   input  logic                               pop,
   output logic [uart_timing_pkg::data_w-1:0] head,
   output logic                               empty,
   output logic                               full
);

   localparam int depth = 2 ** fifo_aw;

   // Byte storage
   logic [uart_timing_pkg::data_w-1:0] mem [depth];

   // Pointers carry one extra wrap bit
   logic [fifo_aw:0] wr_ptr;
   logic [fifo_aw:0] rd_ptr;

   logic do_push;
   logic do_pop;

   // ------------------------------
   // Flags
   // ------------------------------
   assign empty = (wr_ptr == rd_ptr);
   // Same slot on the other lap
   assign full  = (wr_ptr[fifo_aw] != rd_ptr[fifo_aw]) &&
                  (wr_ptr[fifo_aw-1:0] == rd_ptr[fifo_aw-1:0]);

   // Overrun and underrun are dropped here
   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   // Head is visible without a pop
   assign head = mem[rd_ptr[fifo_aw-1:0]];

   // ------------------------------
   // Pointer update
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Write port
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr[fifo_aw-1:0]] <= din;
      end
   end

endmodule

/* hdl/uart_rx.sv */
// UART receive engine

`timescale 1ns/1ps

module uart_rx (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               tick_1us,
   input  logic                               uart_rx,
   output logic [uart_timing_pkg::data_w-1:0] rx_byte,
   output logic                               rx_push
);

   uart_timing_pkg::frame_state_t rx_state;
   uart_timing_pkg::tick_cnt_t    rx_cnt;

   // Two-flop synchronizer for the serial input
   logic rx_meta;
   logic rx_line;

   logic rx_next;
   logic rx_is_data;

   always_ff @(posedge clk) begin
      if (!arst_n) begin
         rx_meta <= 1'b1;
         rx_line <= 1'b1;
      end else begin
         rx_meta <= uart_rx;
         rx_line <= rx_meta;
      end
   end

   // Sample point, count exhausted on a tick
   assign rx_next    = tick_1us && (rx_cnt == '0);
   // D0..D7 have the top state bit clear
   assign rx_is_data = (rx_state[3] == 1'b0);
   // Byte is complete at the stop bit centre, stop value not checked
   assign rx_push    = rx_next && (rx_state == uart_timing_pkg::STOP);

   // ------------------------------
   // Frame FSM
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!arst_n) begin
         rx_state <= uart_timing_pkg::IDLE;
         rx_cnt   <= '0;
      end else begin
         // Count ticks down while in a frame
         if (tick_1us && (rx_state != uart_timing_pkg::IDLE)) begin
            rx_cnt <= uart_timing_pkg::tick_cnt_t'(rx_cnt - 1'b1);
         end

         case (rx_state)
            // Falling edge starts a frame
            // Start bit is skipped, D0 wait covers it
            uart_timing_pkg::IDLE: begin
               rx_cnt <= uart_timing_pkg::rx_wait_tbl[0];
               if (!rx_line) begin
                  rx_state <= uart_timing_pkg::D0;
               end
            end

            uart_timing_pkg::STOP: begin
               if (rx_next) begin
                  rx_state <= uart_timing_pkg::IDLE;
               end
            end

            // Not used by the receiver
            uart_timing_pkg::START: begin
               rx_state <= uart_timing_pkg::IDLE;
            end

            // Data bits, reload for the following bit
            default: begin
               if (rx_next) begin
                  rx_cnt   <= uart_timing_pkg::rx_wait_tbl[rx_state + 4'd1];
                  rx_state <= uart_timing_pkg::frame_state_t'(rx_state + 4'd1);
               end
            end
         endcase
      end
   end

   // LSB arrives first, so shift in at the MSB
   always_ff @(posedge clk) begin
      if (rx_next && rx_is_data) begin
         rx_byte <= {rx_line, rx_byte[uart_timing_pkg::data_w-1:1]};
      end
   end

   // Push ends the frame
   a_push_in_stop: assert property (@(posedge clk) disable iff (!arst_n)
      rx_push |-> (rx_state == uart_timing_pkg::STOP)
                  ##1 (rx_state == uart_timing_pkg::IDLE));

endmodule

/* hdl/uart_tick_gen.sv */
// Microsecond tick generator

`timescale 1ns/1ps

module uart_tick_gen #(
   parameter int clks_per_us = 250
) (
   input  logic clk,
   input  logic arst_n,
   output logic tick_1us
);

   // Wide enough to hold clks_per_us-1
   localparam int cnt_w = (clks_per_us > 1) ? $clog2(clks_per_us) : 1;

   logic [cnt_w-1:0] cnt;
   logic             wrap;

   // Last clock of the microsecond
   assign wrap = (cnt == cnt_w'(clks_per_us - 1));

   always_ff @(posedge clk) begin
      if (!arst_n) begin
         cnt      <= '0;
         tick_1us <= 1'b0;
      end else begin
         tick_1us <= wrap;
         // Restart the count together with the pulse
         if (wrap) begin
            cnt <= '0;
         end else begin
            cnt <= cnt_w'(cnt + 1'b1);
         end
      end
   end

   // Pulse is a single cycle wide
   a_tick_single: assert property (@(posedge clk) disable iff (!arst_n)
      (clks_per_us > 1) && tick_1us |=> !tick_1us);

endmodule

/* hdl/uart_timing_pkg.sv */
// UART serial timing definitions

package uart_timing_pkg;

   // Data bits per frame
   localparam int data_w = 8;

   // Frame position, also used as the index of the wait tables
   typedef enum logic [3:0] {
      D0    = 4'd0,
      D1    = 4'd1,
      D2    = 4'd2,
      D3    = 4'd3,
      D4    = 4'd4,
      D5    = 4'd5,
      D6    = 4'd6,
      D7    = 4'd7,
      STOP  = 4'd8,
      IDLE  = 4'd14,
      START = 4'd15
   } frame_state_t;

   // Count of 1us ticks within one bit
   typedef logic [3:0] tick_cnt_t;

   // ------------------------------
   // Rx reload values, indexed by D0..STOP
   // A reload of N waits N+1 ticks
   // D0 entry skips the start bit and lands near the D0 centre
   // ------------------------------
   localparam tick_cnt_t rx_wait_tbl [0:8] = '{
      4'd13, 4'd7, 4'd8, 4'd8, 4'd7, 4'd8, 4'd8, 4'd7, 4'd8
   };

   // ------------------------------
   // Tx reload values
   // Entry 0 is START, entries 1..8 are D0..D7, entry 9 is STOP
   // START gets one extra tick to sync to the tick grid
   // ------------------------------
   localparam tick_cnt_t tx_wait_tbl [0:9] = '{
      4'd9, 4'd7, 4'd8, 4'd8, 4'd7, 4'd8, 4'd8, 4'd7, 4'd8, 4'd8
   };

endpackage

/* hdl/uart_top.sv */
// UART top level

`timescale 1ns/1ps

module uart_top #(
   parameter int clks_per_us = 250,
   parameter int fifo_aw     = 4
) (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               uart_rx,
   output logic                               uart_tx,
   input  uart_csr_pkg::csr_addr_t            csr_addr,
   input  logic                               csr_wr,
   input  logic [uart_timing_pkg::data_w-1:0] csr_wdata,
   input  logic                               csr_rd,
   output logic [uart_timing_pkg::data_w-1:0] csr_rdata
);

   logic                               tick_1us;

   // Rx path
   logic [uart_timing_pkg::data_w-1:0] rx_byte;
   logic                               rx_push;
   logic [uart_timing_pkg::data_w-1:0] rx_head;
   logic                               rx_empty;
   logic                               rx_full;
   logic                               rx_pop;

   // Tx path
   logic [uart_timing_pkg::data_w-1:0] tx_wdata;
   logic                               tx_push;
   logic [uart_timing_pkg::data_w-1:0] tx_head;
   logic                               tx_empty;
   logic                               tx_full;
   logic                               tx_pop;

   // ------------------------------
   // Shared time base
   // ------------------------------
   uart_tick_gen #(.clks_per_us(clks_per_us)) u_tick_gen (
      .clk      (clk),
      .arst_n   (arst_n),
      .tick_1us (tick_1us)
   );

   // Serial in, bytes into the Rx FIFO
   uart_rx u_rx (
      .clk      (clk),
      .arst_n   (arst_n),
      .tick_1us (tick_1us),
      .uart_rx  (uart_rx),
      .rx_byte  (rx_byte),
      .rx_push  (rx_push)
   );

   uart_fifo #(.fifo_aw(fifo_aw)) u_rx_fifo (
      .clk    (clk),
      .arst_n (arst_n),
      .din    (rx_byte),
      .push   (rx_push),
      .pop    (rx_pop),
      .head   (rx_head),
      .empty  (rx_empty),
      .full   (rx_full)
   );

   // Register writes into the Tx FIFO
   uart_fifo #(.fifo_aw(fifo_aw)) u_tx_fifo (
      .clk    (clk),
      .arst_n (arst_n),
      .din    (tx_wdata),
      .push   (tx_push),
      .pop    (tx_pop),
      .head   (tx_head),
      .empty  (tx_empty),
      .full   (tx_full)
   );

   uart_tx u_tx (
      .clk      (clk),
      .arst_n   (arst_n),
      .tick_1us (tick_1us),
      .tx_head  (tx_head),
      .tx_empty (tx_empty),
      .uart_tx  (uart_tx),
      .tx_pop   (tx_pop)
   );

   // ------------------------------
   // Software view
   // ------------------------------
   uart_csr u_csr (
      .clk       (clk),
      .arst_n    (arst_n),
      .csr_addr  (csr_addr),
      .csr_wr    (csr_wr),
      .csr_rd    (csr_rd),
      .csr_wdata (csr_wdata),
      .csr_rdata (csr_rdata),
      .rx_head   (rx_head),
      .rx_empty  (rx_empty),
      .rx_full   (rx_full),
      .rx_push   (rx_push),
      .tx_full   (tx_full),
      .rx_pop    (rx_pop),
      .tx_push   (tx_push),
      .tx_wdata  (tx_wdata)
   );

endmodule

/* hdl/uart_tx.sv */
// UART transmit engine

`timescale 1ns/1ps

module uart_tx (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               tick_1us,
   input  logic [uart_timing_pkg::data_w-1:0] tx_head,
   input  logic                               tx_empty,
   output logic                               uart_tx,
   output logic                               tx_pop
);

   uart_timing_pkg::frame_state_t tx_state;
   uart_timing_pkg::tick_cnt_t    tx_cnt;

   logic tx_next;

   // Bit edge, count exhausted on a tick
   assign tx_next = tick_1us && (tx_cnt == '0);
   // Byte leaves the FIFO only once the stop bit is done
   assign tx_pop  = tx_next && (tx_state == uart_timing_pkg::STOP);

   // ------------------------------
   // Frame FSM
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!arst_n) begin
         tx_state <= uart_timing_pkg::IDLE;
         tx_cnt   <= '0;
         // Line idles high
         uart_tx  <= 1'b1;
      end else begin
         // Count ticks down while in a frame
         if (tick_1us && (tx_state != uart_timing_pkg::IDLE)) begin
            tx_cnt <= uart_timing_pkg::tick_cnt_t'(tx_cnt - 1'b1);
         end

         case (tx_state)
            // Start as soon as the FIFO holds a byte
            uart_timing_pkg::IDLE: begin
               uart_tx <= 1'b1;
               tx_cnt  <= uart_timing_pkg::tx_wait_tbl[0];
               if (!tx_empty) begin
                  tx_state <= uart_timing_pkg::START;
               end
            end

            // First tick pulls the line low
            // Start bit then runs for its full wait
            uart_timing_pkg::START: begin
               if (tick_1us) begin
                  uart_tx <= 1'b0;
                  if (tx_cnt == '0) begin
                     uart_tx  <= tx_head[0];
                     tx_cnt   <= uart_timing_pkg::tx_wait_tbl[1];
                     tx_state <= uart_timing_pkg::D0;
                  end
               end
            end

            // Stop bit already on the line
            uart_timing_pkg::STOP: begin
               if (tx_next) begin
                  tx_state <= uart_timing_pkg::IDLE;
               end
            end

            // Data bits, next bit or stop after D7
            default: begin
               if (tx_next) begin
                  if (tx_state == uart_timing_pkg::D7) begin
                     uart_tx <= 1'b1;
                  end else begin
                     uart_tx <= tx_head[tx_state[2:0] + 3'd1];
                  end
                  // Table entry k+1 belongs to Dk, so the next bit is k+2
                  tx_cnt   <= uart_timing_pkg::tx_wait_tbl[tx_state + 4'd2];
                  tx_state <= uart_timing_pkg::frame_state_t'(tx_state + 4'd1);
               end
            end
         endcase
      end
   end

   // FIFO keeps the byte in flight until the frame ends
   a_head_held: assert property (@(posedge clk) disable iff (!arst_n)
      (tx_state != uart_timing_pkg::IDLE) |-> !tx_empty);

endmodule

/* tb/tb_uart.sv */
// UART testbench

`timescale 1ns/1ps

module tb_uart;

   typedef logic [uart_timing_pkg::data_w-1:0] byte_t;

   // 4 ns clock, 8680 ns serial bit
   localparam int clk_ns      = 4;
   localparam int bit_clks    = 8680 / clk_ns;
   localparam int frame_clks  = 90_000 / clk_ns;
   localparam int fifo_depth  = 16;
   localparam int watchdog_ns = 60 * 90_000;

   logic                    clk;
   logic                    arst_n;
   logic                    uart_rx;
   logic                    uart_tx;
   uart_csr_pkg::csr_addr_t csr_addr;
   logic                    csr_wr;
   byte_t                   csr_wdata;
   logic                    csr_rd;
   byte_t                   csr_rdata;

   // Expected bytes, each direction
   byte_t tx_exp [$];
   byte_t rx_exp [$];
   logic  exp_oflow;
   logic  mon_busy;
   int    errors;
   int    frames_sent;
   int    frames_seen;

   uart_top #(.clks_per_us(250), .fifo_aw(4)) i_uart_top (
      .clk       (clk),
      .arst_n    (arst_n),
      .uart_rx   (uart_rx),
      .uart_tx   (uart_tx),
      .csr_addr  (csr_addr),
      .csr_wr    (csr_wr),
      .csr_wdata (csr_wdata),
      .csr_rd    (csr_rd),
      .csr_rdata (csr_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_ns / 2) clk = ~clk;
   end

   // ------------------------------
   // Reporting
   // ------------------------------
   task automatic report_mismatch(input string msg);
      $display("FAILED at %0t ns: %s", $time, msg);
      errors++;
   endtask

   task automatic report_problem(input string msg);
      $display("ERROR: %s", msg);
      errors++;
   endtask

   // Read data only moves on a read
   a_rdata_hold: assert property (@(posedge clk) disable iff (!arst_n)
      !csr_rd |=> $stable(csr_rdata))
      else report_mismatch("csr_rdata changed without a read");

   // Line idles high out of reset
   a_tx_reset_high: assert property (@(posedge clk) !arst_n |=> uart_tx)
      else report_mismatch("uart_tx not high during reset");

   // ------------------------------
   // Register access
   // ------------------------------
   // Result is registered, taken one cycle after the strobe drops
   task automatic read_reg(input uart_csr_pkg::csr_addr_t addr, output byte_t value);
      @(posedge clk);
      csr_addr <= addr;
      csr_rd   <= 1'b1;
      @(posedge clk);
      csr_rd   <= 1'b0;
      @(posedge clk);
      value = csr_rdata;
   endtask

   // Back to back DATA writes, TX FIFO assumed empty at the start
   task automatic write_burst(input int count);
      byte_t value;
      for (int i = 0; i < count; i++) begin
         value = byte_t'($urandom());
         @(posedge clk);
         csr_addr  <= uart_csr_pkg::csr_addr_data;
         csr_wdata <= value;
         csr_wr    <= 1'b1;
         // Full FIFO drops the write
         if (i < fifo_depth) begin
            tx_exp.push_back(value);
         end
      end
      @(posedge clk);
      csr_wr <= 1'b0;
   endtask

   task automatic check_status(input logic exp_valid, input logic exp_ovf,
                               input logic exp_busy, input string what);
      uart_csr_pkg::csr_word_u w;
      byte_t                   raw;
      read_reg(uart_csr_pkg::csr_addr_status, raw);
      w.data = raw;
      assert (w.status.rx_valid == exp_valid) else report_mismatch(
         $sformatf("%s: rx_valid %0b, expected %0b", what, w.status.rx_valid, exp_valid));
      assert (w.status.rx_oflow == exp_ovf) else report_mismatch(
         $sformatf("%s: rx_oflow %0b, expected %0b", what, w.status.rx_oflow, exp_ovf));
      assert (w.status.tx_busy == exp_busy) else report_mismatch(
         $sformatf("%s: tx_busy %0b, expected %0b", what, w.status.tx_busy, exp_busy));
      assert (w.status.rsvd == '0) else report_mismatch(
         $sformatf("%s: reserved bits %05b not zero", what, w.status.rsvd));
   endtask

   // DATA read pops the oldest byte and clears the overflow flag
   task automatic check_data_read();
      byte_t got;
      byte_t exp;
      read_reg(uart_csr_pkg::csr_addr_data, got);
      exp_oflow = 1'b0;
      if (rx_exp.size() == 0) begin
         report_problem("DATA read with no byte expected in the receive FIFO");
      end else begin
         exp = rx_exp.pop_front();
         assert (got == exp) else report_mismatch(
            $sformatf("DATA read %02h, expected %02h", got, exp));
      end
   endtask

   task automatic check_unused(input uart_csr_pkg::csr_addr_t addr);
      byte_t raw;
      read_reg(addr, raw);
      assert (raw == '0) else report_mismatch(
         $sformatf("address %0d read %02h, expected 00", addr, raw));
   endtask

   // ------------------------------
   // Serial side
   // ------------------------------
   // Start, 8 data bits LSB first, stop
   task automatic send_frame(input byte_t value);
      logic [9:0] bits;
      bits = {1'b1, value, 1'b0};
      @(posedge clk);
      for (int i = 0; i < 10; i++) begin
         uart_rx <= bits[i];
         repeat (bit_clks) @(posedge clk);
      end
      frames_sent++;
      // RX FIFO model, a full FIFO loses the byte
      if (rx_exp.size() < fifo_depth) begin
         rx_exp.push_back(value);
      end else begin
         exp_oflow = 1'b1;
      end
   endtask

   task automatic wait_tx_drain(input int limit_clks);
      int n;
      n = 0;
      while ((tx_exp.size() != 0 || mon_busy) && n < limit_clks) begin
         @(posedge clk);
         n++;
      end
      if (tx_exp.size() != 0 || mon_busy) begin
         report_problem("transmit frames did not arrive before the timeout");
      end
   endtask

   task automatic wait_tx_not_busy(input int limit_reads);
      uart_csr_pkg::csr_word_u w;
      byte_t                   raw;
      int                      n;
      n = 0;
      w.data = '1;
      while (w.status.tx_busy && n < limit_reads) begin
         read_reg(uart_csr_pkg::csr_addr_status, raw);
         w.data = raw;
         n++;
      end
      assert (!w.status.tx_busy) else report_mismatch("tx_busy stayed set");
   endtask

   // Samples at bit centres counted from the start edge
   initial begin : tx_monitor
      byte_t got;
      byte_t exp;
      mon_busy = 1'b0;
      wait (arst_n == 1'b1);
      forever begin
         @(negedge uart_tx);
         mon_busy = 1'b1;
         repeat (bit_clks / 2) @(negedge clk);
         assert (uart_tx == 1'b0) else report_mismatch("start bit not low");
         for (int i = 0; i < uart_timing_pkg::data_w; i++) begin
            repeat (bit_clks) @(negedge clk);
            got[i] = uart_tx;
         end
         repeat (bit_clks) @(negedge clk);
         assert (uart_tx == 1'b1) else report_mismatch("stop bit not high");
         if (tx_exp.size() == 0) begin
            report_problem($sformatf("unexpected frame on uart_tx, byte %02h", got));
         end else begin
            exp = tx_exp.pop_front();
            assert (got == exp) else report_mismatch(
               $sformatf("uart_tx byte %02h, expected %02h", got, exp));
         end
         frames_seen++;
         mon_busy = 1'b0;
      end
   end

   initial begin : watchdog
      #(watchdog_ns);
      $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
      $display("FAIL: see errors above");
      $finish;
   end

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin : main
      int seen_before;
      void'($urandom(32'hca52_e5bf));
      errors      = 0;
      frames_sent = 0;
      frames_seen = 0;
      exp_oflow   = 1'b0;
      arst_n    <= 1'b0;
      uart_rx   <= 1'b1;
      csr_addr  <= '0;
      csr_wr    <= 1'b0;
      csr_wdata <= '0;
      csr_rd    <= 1'b0;
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;

      // Reset state
      @(negedge clk);
      assert (uart_tx === 1'b1) else report_mismatch("uart_tx not high after reset");
      check_status(1'b0, 1'b0, 1'b0, "after reset");
      check_unused(2'd2);
      check_unused(2'd3);

      // Transmit framing and order
      write_burst(4);
      wait_tx_drain(6 * frame_clks);

      // Receive path
      for (int i = 0; i < 3; i++) begin
         send_frame(byte_t'($urandom()));
         check_status(1'b1, exp_oflow, 1'b0, "after a received frame");
      end
      repeat (3) check_data_read();
      check_status(1'b0, 1'b0, 1'b0, "receive FIFO read out");

      // Overflow, 17th frame is lost
      repeat (fifo_depth + 1) send_frame(byte_t'($urandom()));
      check_status(1'b1, exp_oflow, 1'b0, "after 17 frames");
      check_data_read();
      check_status(1'b1, exp_oflow, 1'b0, "after the first read");
      repeat (fifo_depth - 1) check_data_read();
      check_status(rx_exp.size() != 0, exp_oflow, 1'b0, "after 16 reads");

      // Back-pressure, 17th write is dropped
      write_burst(fifo_depth + 1);
      check_status(1'b0, 1'b0, 1'b1, "after 17 writes");
      seen_before = frames_seen;
      wait_tx_not_busy(2 * frame_clks / 3);
      assert (frames_seen == seen_before + 1) else report_mismatch(
         $sformatf("tx_busy cleared after %0d frames", frames_seen - seen_before));
      wait_tx_drain((fifo_depth + 2) * frame_clks);
      // Quiet line, room for a stray 17th frame to show up
      repeat (frame_clks) @(posedge clk);
      assert (frames_seen == seen_before + fifo_depth) else report_mismatch(
         $sformatf("%0d frames after the burst, expected %0d",
                   frames_seen - seen_before, fifo_depth));

      $display("errors: %0d, frames sent: %0d, frames seen: %0d",
               errors, frames_sent, frames_seen);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule
